//--- logic/mon_lookup_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Monitoring lookup shared definitions
// Widths, bus address map and vector
// types used by the control side
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mon_lookup_pkg;

	// Widths
	localparam int data_w      = 32;
	localparam int adr_w       = 12;
	localparam int stamp_w     = 64;
	localparam int num_classes = 4;
	localparam int class_w     = 2;
	localparam int len_w       = 16;
	localparam int tbl_rows    = 16;
	localparam int tbl_cols    = 8;
	localparam int row_w       = 4;
	localparam int col_w       = 3;
	localparam int proto_w     = 8;

	// Address map, byte addresses with word index from bit 2
	localparam int win_bit    = 11;
	localparam int word_lsb   = 2;
	localparam int stat_idx_w = 5;
	localparam int row_lsb    = 5;

	// Statistics window words
	localparam int reg_rst_stats  = 0;
	localparam int reg_freeze     = 1;
	localparam int reg_pkt_base   = 2;
	localparam int reg_bytes_base = 6;
	localparam int reg_time_low   = 10;
	localparam int reg_time_high  = 11;

	// Rule table columns, proto pair last
	localparam int col_sip          = 0;
	localparam int col_sip_mask     = 1;
	localparam int col_dip          = 2;
	localparam int col_dip_mask     = 3;
	localparam int col_l4ports      = 4;
	localparam int col_l4ports_mask = 5;
	localparam int col_proto        = 6;
	localparam int col_proto_mask   = 7;

	typedef logic [data_w-1:0]          word_t;
	typedef logic [adr_w-1:0]           bus_adr_t;
	typedef logic [stamp_w-1:0]         stamp_t;
	typedef logic [class_w-1:0]         pkt_class_t;
	typedef logic [len_w-1:0]           pkt_len_t;
	typedef logic [row_w-1:0]           row_idx_t;
	typedef logic [tbl_cols*data_w-1:0] rule_row_t;

endpackage

`default_nettype wire

//--- logic/mon_stats_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Monitoring statistics registers
// Control bits, per-class packet and byte
// counters, last-packet timestamp and the
// window-0 register access
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mon_stats_regs (
	input  wire                         Bus2IP_Clk,
	input  wire                         reset,
	input  wire                         sel,
	input  wire                         we,
	input  wire mon_lookup_pkg::bus_adr_t   adr,
	input  wire mon_lookup_pkg::word_t      dat_w,
	input  wire                         pkt_valid,
	input  wire mon_lookup_pkg::pkt_class_t pkt_class,
	input  wire mon_lookup_pkg::pkt_len_t   pkt_len,
	input  wire mon_lookup_pkg::stamp_t     stamp_counter,
	output mon_lookup_pkg::word_t           rd_data,
	output logic                        done
);

	mon_lookup_pkg::word_t  rst_stats_reg;
	mon_lookup_pkg::word_t  freeze_reg;
	mon_lookup_pkg::word_t  pkt_cnt [mon_lookup_pkg::num_classes];
	mon_lookup_pkg::word_t  byte_cnt [mon_lookup_pkg::num_classes];
	mon_lookup_pkg::stamp_t last_stamp;
	mon_lookup_pkg::word_t  rd_word;

	logic [mon_lookup_pkg::stat_idx_w-1:0] idx;
	logic served;
	logic access;

	assign idx = adr[mon_lookup_pkg::word_lsb +: mon_lookup_pkg::stat_idx_w];

	// One access per bus cycle
	assign access = sel && !served;

	always_ff @(posedge Bus2IP_Clk) begin
		if (reset) begin
			rst_stats_reg <= '0;
			freeze_reg <= '0;
			served <= 1'b0;
			done <= 1'b0;
		end else begin
			served <= sel;
			done <= access;
			if (access && we) begin
				case (idx)
					mon_lookup_pkg::reg_rst_stats: rst_stats_reg <= dat_w;
					mon_lookup_pkg::reg_freeze: freeze_reg <= dat_w;
					// Counter and timestamp words ignore writes
					default: ;
				endcase
			end
		end
	end

	// Clearing wins over counting
	always_ff @(posedge Bus2IP_Clk) begin
		if (reset || rst_stats_reg[0]) begin
			for (int i = 0; i < mon_lookup_pkg::num_classes; i++) begin
				pkt_cnt[i] <= '0;
				byte_cnt[i] <= '0;
			end
			last_stamp <= '0;
		end else if (pkt_valid && !freeze_reg[0]) begin
			pkt_cnt[pkt_class] <= pkt_cnt[pkt_class] + 1'b1;
			byte_cnt[pkt_class] <= byte_cnt[pkt_class] + mon_lookup_pkg::word_t'(pkt_len);
			last_stamp <= stamp_counter;
		end
	end

	// Window-0 read mux
	always_comb begin
		rd_word = '0;
		if (idx == mon_lookup_pkg::reg_rst_stats) begin
			rd_word = rst_stats_reg;
		end else if (idx == mon_lookup_pkg::reg_freeze) begin
			rd_word = freeze_reg;
		end else if (idx >= mon_lookup_pkg::reg_pkt_base &&
				idx < mon_lookup_pkg::reg_bytes_base) begin
			rd_word = pkt_cnt[mon_lookup_pkg::pkt_class_t'(idx - mon_lookup_pkg::reg_pkt_base)];
		end else if (idx >= mon_lookup_pkg::reg_bytes_base &&
				idx < mon_lookup_pkg::reg_time_low) begin
			rd_word = byte_cnt[mon_lookup_pkg::pkt_class_t'(idx - mon_lookup_pkg::reg_bytes_base)];
		end else if (idx == mon_lookup_pkg::reg_time_low) begin
			rd_word = last_stamp[mon_lookup_pkg::data_w-1:0];
		end else if (idx == mon_lookup_pkg::reg_time_high) begin
			rd_word = last_stamp[mon_lookup_pkg::stamp_w-1:mon_lookup_pkg::data_w];
		end
	end

	// Read data held until the next access
	always_ff @(posedge Bus2IP_Clk) begin
		if (access) begin
			rd_data <= rd_word;
		end
	end

endmodule

`default_nettype wire

//--- logic/mon_rule_table.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Monitoring rule table
// 16 rows of eight columns with bus
// access and a one-cycle lookup port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mon_rule_table (
	input  wire                       Bus2IP_Clk,
	input  wire                       reset,
	input  wire                       sel,
	input  wire                       we,
	input  wire mon_lookup_pkg::bus_adr_t adr,
	input  wire mon_lookup_pkg::word_t    dat_w,
	input  wire mon_lookup_pkg::row_idx_t lkp_addr,
	output mon_lookup_pkg::word_t         rd_data,
	output logic                      done,
	output mon_lookup_pkg::rule_row_t     lkp_rule
);

	localparam int pad_w = mon_lookup_pkg::data_w - mon_lookup_pkg::proto_w;

	// Six full-width columns sit below the proto pair
	mon_lookup_pkg::word_t wide_mem [mon_lookup_pkg::tbl_rows][mon_lookup_pkg::col_proto];
	logic [mon_lookup_pkg::proto_w-1:0] proto_mem [mon_lookup_pkg::tbl_rows];
	logic [mon_lookup_pkg::proto_w-1:0] proto_mask_mem [mon_lookup_pkg::tbl_rows];

	mon_lookup_pkg::row_idx_t row;
	logic [mon_lookup_pkg::col_w-1:0] col;
	mon_lookup_pkg::word_t rd_word;
	logic served;
	logic access;

	assign row = adr[mon_lookup_pkg::row_lsb +: mon_lookup_pkg::row_w];
	assign col = adr[mon_lookup_pkg::word_lsb +: mon_lookup_pkg::col_w];
	assign access = sel && !served;

	always_ff @(posedge Bus2IP_Clk) begin
		if (reset) begin
			served <= 1'b0;
			done <= 1'b0;
		end else begin
			served <= sel;
			done <= access;
		end
	end

	// Storage, only the low byte of proto columns is kept
	always_ff @(posedge Bus2IP_Clk) begin
		if (access && we) begin
			if (col == mon_lookup_pkg::col_proto) begin
				proto_mem[row] <= dat_w[mon_lookup_pkg::proto_w-1:0];
			end else if (col == mon_lookup_pkg::col_proto_mask) begin
				proto_mask_mem[row] <= dat_w[mon_lookup_pkg::proto_w-1:0];
			end else begin
				wide_mem[row][col] <= dat_w;
			end
		end
	end

	always_comb begin
		if (col == mon_lookup_pkg::col_proto) begin
			rd_word = {{pad_w{1'b0}}, proto_mem[row]};
		end else if (col == mon_lookup_pkg::col_proto_mask) begin
			rd_word = {{pad_w{1'b0}}, proto_mask_mem[row]};
		end else begin
			rd_word = wide_mem[row][col];
		end
	end

	always_ff @(posedge Bus2IP_Clk) begin
		if (access) begin
			rd_data <= rd_word;
		end
	end

	// Lookup path, column 0 in the low word
	always_ff @(posedge Bus2IP_Clk) begin
		lkp_rule <= {{pad_w{1'b0}}, proto_mask_mem[lkp_addr],
			{pad_w{1'b0}}, proto_mem[lkp_addr],
			wide_mem[lkp_addr][mon_lookup_pkg::col_l4ports_mask],
			wide_mem[lkp_addr][mon_lookup_pkg::col_l4ports],
			wide_mem[lkp_addr][mon_lookup_pkg::col_dip_mask],
			wide_mem[lkp_addr][mon_lookup_pkg::col_dip],
			wide_mem[lkp_addr][mon_lookup_pkg::col_sip_mask],
			wide_mem[lkp_addr][mon_lookup_pkg::col_sip]};
	end

endmodule

`default_nettype wire

//--- logic/bus_window_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone window decoder
// Selects statistics or table window and
// merges their responses into one ack
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module bus_window_decoder (
	input  wire                       Bus2IP_Clk,
	input  wire                       reset,
	input  wire                       wb_cyc,
	input  wire                       wb_stb,
	input  wire mon_lookup_pkg::bus_adr_t wb_adr,
	input  wire mon_lookup_pkg::word_t    stats_rd_data,
	input  wire                       stats_done,
	input  wire mon_lookup_pkg::word_t    table_rd_data,
	input  wire                       table_done,
	output logic                      stats_sel,
	output logic                      table_sel,
	output mon_lookup_pkg::word_t         wb_dat_r,
	output logic                      wb_ack
);

	logic bus_req;

	// Active bus cycle, window picked by the address
	assign bus_req = wb_cyc && wb_stb;
	assign stats_sel = bus_req && !wb_adr[mon_lookup_pkg::win_bit];
	assign table_sel = bus_req && wb_adr[mon_lookup_pkg::win_bit];

	// Acknowledge one cycle after either window finishes
	always_ff @(posedge Bus2IP_Clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= stats_done || table_done;
		end
	end

	// Zero when no window answers
	always_ff @(posedge Bus2IP_Clk) begin
		if (stats_done) begin
			wb_dat_r <= stats_rd_data;
		end else if (table_done) begin
			wb_dat_r <= table_rd_data;
		end else begin
			wb_dat_r <= '0;
		end
	end

endmodule

`default_nettype wire

//--- logic/mon_lookup_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Monitoring lookup control top
// Wishbone slave over the statistics block
// and the monitoring rule table
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mon_lookup_top (
	input  wire                         Bus2IP_Clk,
	input  wire                         reset,
	// Wishbone slave
	input  wire                         wb_cyc,
	input  wire                         wb_stb,
	input  wire                         wb_we,
	input  wire mon_lookup_pkg::bus_adr_t   wb_adr,
	input  wire mon_lookup_pkg::word_t      wb_dat_w,
	output mon_lookup_pkg::word_t           wb_dat_r,
	output logic                        wb_ack,
	// Packet events
	input  wire                         pkt_valid,
	input  wire mon_lookup_pkg::pkt_class_t pkt_class,
	input  wire mon_lookup_pkg::pkt_len_t   pkt_len,
	// Time reference
	input  wire mon_lookup_pkg::stamp_t     stamp_counter,
	// Classifier lookup
	input  wire mon_lookup_pkg::row_idx_t   lkp_addr,
	output mon_lookup_pkg::rule_row_t       lkp_rule
);

	wire stats_sel;
	wire table_sel;
	wire stats_done;
	wire table_done;
	wire mon_lookup_pkg::word_t stats_rd_data;
	wire mon_lookup_pkg::word_t table_rd_data;

	mon_stats_regs i_stats (
		.Bus2IP_Clk    (Bus2IP_Clk),
		.reset         (reset),
		.sel           (stats_sel),
		.we            (wb_we),
		.adr           (wb_adr),
		.dat_w         (wb_dat_w),
		.pkt_valid     (pkt_valid),
		.pkt_class     (pkt_class),
		.pkt_len       (pkt_len),
		.stamp_counter (stamp_counter),
		.rd_data       (stats_rd_data),
		.done          (stats_done)
	);

	mon_rule_table i_table (
		.Bus2IP_Clk (Bus2IP_Clk),
		.reset      (reset),
		.sel        (table_sel),
		.we         (wb_we),
		.adr        (wb_adr),
		.dat_w      (wb_dat_w),
		.lkp_addr   (lkp_addr),
		.rd_data    (table_rd_data),
		.done       (table_done),
		.lkp_rule   (lkp_rule)
	);

	bus_window_decoder i_decoder (
		.Bus2IP_Clk    (Bus2IP_Clk),
		.reset         (reset),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_adr        (wb_adr),
		.stats_rd_data (stats_rd_data),
		.stats_done    (stats_done),
		.table_rd_data (table_rd_data),
		.table_done    (table_done),
		.stats_sel     (stats_sel),
		.table_sel     (table_sel),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack)
	);

endmodule

`default_nettype wire

//--- sim/tb_bus_tasks.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench bus tasks and reference model
// Wishbone classic accesses, xorshift
// random numbers and expected values
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// Ack arrives two cycles after the request is first sampled
localparam int ack_latency = 2;

// Xorshift32 step
function automatic mon_lookup_pkg::word_t xorshift(input mon_lookup_pkg::word_t x);
	mon_lookup_pkg::word_t y;
	y = x;
	y = y ^ (y << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic mon_lookup_pkg::bus_adr_t stats_addr(input int idx);
	return mon_lookup_pkg::bus_adr_t'(idx << mon_lookup_pkg::word_lsb);
endfunction

function automatic mon_lookup_pkg::bus_adr_t table_addr(input int row, input int col);
	return mon_lookup_pkg::bus_adr_t'((1 << mon_lookup_pkg::win_bit) |
		(row << mon_lookup_pkg::row_lsb) | (col << mon_lookup_pkg::word_lsb));
endfunction

// One classic cycle held until ack or until ack_limit cycles pass
task automatic bus_access(input logic write, input mon_lookup_pkg::bus_adr_t adr,
		input mon_lookup_pkg::word_t data, output mon_lookup_pkg::word_t rdata);
	int waited;
	@(negedge Bus2IP_Clk);
	// Ack of the previous access lasts a single cycle
	check_value("ack_pulse", '0, mon_lookup_pkg::word_t'(wb_ack));
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we = write;
	wb_adr = adr;
	wb_dat_w = data;
	waited = 0;
	rdata = '0;
	do begin
		@(negedge Bus2IP_Clk);
		waited++;
	end while (!wb_ack && waited < ack_limit);
	if (wb_ack) begin
		rdata = wb_dat_r;
		check_value("ack_latency", mon_lookup_pkg::word_t'(ack_latency),
			mon_lookup_pkg::word_t'(waited));
	end else begin
		$display("Bus failure: no wb_ack within %0d cycles at address %h", ack_limit, adr);
		bus_errors++;
	end
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we = 1'b0;
endtask

task automatic bus_read(input mon_lookup_pkg::bus_adr_t adr,
		output mon_lookup_pkg::word_t rdata);
	bus_access(1'b0, adr, '0, rdata);
endtask

// Writes below also update the shadow state
task automatic stats_write(input int idx, input mon_lookup_pkg::word_t data);
	mon_lookup_pkg::word_t unused;
	bus_access(1'b1, stats_addr(idx), data, unused);
	if (idx == mon_lookup_pkg::reg_rst_stats) begin
		model_rst = data;
		if (data[0]) begin
			clear_model_counts();
		end
	end else if (idx == mon_lookup_pkg::reg_freeze) begin
		model_freeze = data;
	end
endtask

task automatic table_write(input int row, input int col, input mon_lookup_pkg::word_t data);
	mon_lookup_pkg::word_t unused;
	bus_access(1'b1, table_addr(row, col), data, unused);
	model_tbl[row][col] = data;
endtask

task automatic clear_model_counts();
	for (int c = 0; c < mon_lookup_pkg::num_classes; c++) begin
		model_pkt[c] = '0;
		model_bytes[c] = '0;
	end
	model_stamp = '0;
endtask

// Events are dropped while frozen or held in clear
task automatic model_event(input int cls, input mon_lookup_pkg::word_t len,
		input mon_lookup_pkg::stamp_t stamp);
	if (!model_rst[0] && !model_freeze[0]) begin
		model_pkt[cls] = model_pkt[cls] + 1;
		model_bytes[cls] = model_bytes[cls] + len;
		model_stamp = stamp;
	end
endtask

function automatic mon_lookup_pkg::word_t expected_stats(input int idx);
	if (idx == mon_lookup_pkg::reg_rst_stats) return model_rst;
	if (idx == mon_lookup_pkg::reg_freeze) return model_freeze;
	if (idx >= mon_lookup_pkg::reg_pkt_base && idx < mon_lookup_pkg::reg_bytes_base)
		return model_pkt[idx - mon_lookup_pkg::reg_pkt_base];
	if (idx >= mon_lookup_pkg::reg_bytes_base && idx < mon_lookup_pkg::reg_time_low)
		return model_bytes[idx - mon_lookup_pkg::reg_bytes_base];
	if (idx == mon_lookup_pkg::reg_time_low) return model_stamp[31:0];
	if (idx == mon_lookup_pkg::reg_time_high) return model_stamp[63:32];
	return '0;
endfunction

// Proto pair keeps its low byte only
function automatic mon_lookup_pkg::word_t expected_table(input int row, input int col);
	if (col == mon_lookup_pkg::col_proto || col == mon_lookup_pkg::col_proto_mask)
		return model_tbl[row][col] & ((1 << mon_lookup_pkg::proto_w) - 1);
	return model_tbl[row][col];
endfunction

function automatic mon_lookup_pkg::rule_row_t expected_row(input int row);
	mon_lookup_pkg::rule_row_t packed_row;
	for (int c = 0; c < mon_lookup_pkg::tbl_cols; c++) begin
		packed_row[c*mon_lookup_pkg::data_w +: mon_lookup_pkg::data_w] = expected_table(row, c);
	end
	return packed_row;
endfunction

`endif

//--- sim/tb_mon_lookup.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Monitoring lookup testbench
// Bus, lookup port and packet counting
// checked against a reference model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_mon_lookup;

	localparam int clk_period = 8;
	localparam int reset_cycles = 8;
	localparam int ack_limit = 4;
	// Generous bound on the sequence below, watchdog allows twice that
	localparam int test_cycles = 10000;
	localparam int watchdog_cycles = 2 * test_cycles;

	logic Bus2IP_Clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	mon_lookup_pkg::bus_adr_t wb_adr;
	mon_lookup_pkg::word_t wb_dat_w;
	mon_lookup_pkg::word_t wb_dat_r;
	logic wb_ack;
	logic pkt_valid;
	mon_lookup_pkg::pkt_class_t pkt_class;
	mon_lookup_pkg::pkt_len_t pkt_len;
	mon_lookup_pkg::stamp_t stamp_counter;
	mon_lookup_pkg::row_idx_t lkp_addr;
	mon_lookup_pkg::rule_row_t lkp_rule;

	// Shadow state of the DUT
	mon_lookup_pkg::word_t model_tbl [mon_lookup_pkg::tbl_rows][mon_lookup_pkg::tbl_cols];
	mon_lookup_pkg::word_t model_pkt [mon_lookup_pkg::num_classes];
	mon_lookup_pkg::word_t model_bytes [mon_lookup_pkg::num_classes];
	mon_lookup_pkg::stamp_t model_stamp;
	mon_lookup_pkg::word_t model_rst;
	mon_lookup_pkg::word_t model_freeze;
	mon_lookup_pkg::word_t rng;
	int check_errors;
	int bus_errors;

	`include "tb_bus_tasks.svh"

	mon_lookup_top i_dut (.*);

	initial begin
		Bus2IP_Clk = 1'b0;
		forever #(clk_period / 2) Bus2IP_Clk = ~Bus2IP_Clk;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge Bus2IP_Clk);
		$display("Watchdog expired after %0d cycles, the test sequence did not finish",
			watchdog_cycles);
		$display("=== FAIL ===");
		$finish;
	end

	task automatic check_value(input string name, input mon_lookup_pkg::word_t expected,
			input mon_lookup_pkg::word_t actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			check_errors++;
		end
	endtask

	task automatic check_all_stats(input string name);
		mon_lookup_pkg::word_t rdata;
		for (int idx = 0; idx <= mon_lookup_pkg::reg_time_high; idx++) begin
			bus_read(stats_addr(idx), rdata);
			check_value(name, expected_stats(idx), rdata);
		end
	endtask

	// One event per cycle, stamp moves forward by a random step
	task automatic send_events(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge Bus2IP_Clk);
			rng = xorshift(rng);
			pkt_class = rng[1:0];
			pkt_len = rng[31:16];
			stamp_counter = stamp_counter + 64'(rng[9:2]) + 64'd1;
			pkt_valid = 1'b1;
			model_event(int'(pkt_class), mon_lookup_pkg::word_t'(pkt_len), stamp_counter);
		end
		@(negedge Bus2IP_Clk);
		pkt_valid = 1'b0;
	endtask

	initial begin
		mon_lookup_pkg::word_t rdata;
		mon_lookup_pkg::rule_row_t exp_row;
		int row;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		pkt_valid = 1'b0;
		pkt_class = '0;
		pkt_len = '0;
		stamp_counter = 64'h0000_0003_ffff_ff00;
		lkp_addr = '0;
		rng = 32'h9f5;
		check_errors = 0;
		bus_errors = 0;
		model_rst = '0;
		model_freeze = '0;
		clear_model_counts();
		repeat (reset_cycles) @(negedge Bus2IP_Clk);
		reset = 1'b0;

		check_all_stats("reset_values");
		bus_read(stats_addr(12), rdata);
		check_value("unmapped_word", '0, rdata);

		// Fill every cell, then read all back
		for (int r = 0; r < mon_lookup_pkg::tbl_rows; r++) begin
			for (int c = 0; c < mon_lookup_pkg::tbl_cols; c++) begin
				rng = xorshift(rng);
				table_write(r, c, rng);
			end
		end
		for (int r = 0; r < mon_lookup_pkg::tbl_rows; r++) begin
			for (int c = 0; c < mon_lookup_pkg::tbl_cols; c++) begin
				bus_read(table_addr(r, c), rdata);
				check_value("table_readback", expected_table(r, c), rdata);
			end
		end

		// Row shows one cycle after the address
		repeat (16) begin
			@(negedge Bus2IP_Clk);
			rng = xorshift(rng);
			lkp_addr = rng[3:0];
			row = int'(lkp_addr);
			@(negedge Bus2IP_Clk);
			exp_row = expected_row(row);
			for (int c = 0; c < mon_lookup_pkg::tbl_cols; c++) begin
				check_value("lookup_row", exp_row[c*32 +: 32], lkp_rule[c*32 +: 32]);
			end
		end

		send_events(48);
		check_all_stats("counting");
		stats_write(mon_lookup_pkg::reg_freeze, 32'd1);
		send_events(24);
		check_all_stats("freeze_hold");
		stats_write(mon_lookup_pkg::reg_freeze, 32'd0);
		send_events(24);
		check_all_stats("freeze_resume");
		stats_write(mon_lookup_pkg::reg_rst_stats, 32'd1);
		check_all_stats("rst_stats_clear");
		send_events(24);
		check_all_stats("rst_stats_hold");
		stats_write(mon_lookup_pkg::reg_rst_stats, 32'd0);
		send_events(32);
		check_all_stats("rst_stats_resume");

		$display("Errors: %0d value mismatches, %0d bus failures", check_errors, bus_errors);
		if (check_errors == 0 && bus_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+sim
logic/mon_lookup_pkg.sv
logic/mon_stats_regs.sv
logic/mon_rule_table.sv
logic/bus_window_decoder.sv
logic/mon_lookup_top.sv
sim/tb_mon_lookup.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the monitoring lookup testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_mon_lookup -Mdir "$BUILD_DIR" -o tb_mon_lookup
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$BUILD_DIR/tb_mon_lookup" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi
exit 0
